//--- sensor_pkg.sv
/*
 * shared constants for the sensor hub
 * widths, host command bytes, frame markers
 * MPR121 and ADS1292 register tables, ADS1292 control codes
 */
`default_nettype none

package sensor_pkg;

	// ==============================
	// widths
	// ==============================
	localparam int REG_ADDR_W = 8;
	localparam int REG_DATA_W = 8;
	localparam int SAMPLE_W   = 24;   // ads ch2 sample
	localparam int TOUCH_W    = 16;   // upper nibble always zero
	localparam int FRAME_W    = 56;   // head + sample + touch + tail
	localparam int RX_W       = 16;   // command in upper byte
	localparam int CFG_IDX_W  = 4;    // table walk index
	localparam int SETTLE_W   = 5;

	// ==============================
	// host protocol
	// ==============================
	localparam logic [7:0] CMD_RUN    = 8'h52;   // 'R'
	localparam logic [7:0] CMD_STOP   = 8'h53;   // 'S'
	localparam logic [7:0] FRAME_HEAD = 8'hAA;
	localparam logic [7:0] FRAME_TAIL = 8'hBB;

	localparam logic [SETTLE_W-1:0] SETTLE_CYCLES = 5'd16;   // let other stages leave reset

	typedef struct packed {
		logic [REG_ADDR_W-1:0] addr;
		logic [REG_DATA_W-1:0] data;
	} reg_pair_t;

	// ==============================
	// MPR121
	// ==============================
	localparam logic [REG_ADDR_W-1:0] MPR_TOUCH0_REG  = 8'h00;   // ele0..7
	localparam logic [REG_ADDR_W-1:0] MPR_TOUCH1_REG  = 8'h01;   // ele8..11 in low nibble
	localparam logic [REG_ADDR_W-1:0] MPR_ELE_CFG_REG = 8'h5E;
	localparam logic [REG_DATA_W-1:0] MPR_ELE_RUN     = 8'h8F;   // all 12 electrodes on
	localparam logic [REG_DATA_W-1:0] MPR_ELE_STOP    = 8'h00;

	localparam logic [CFG_IDX_W-1:0] MPR_CFG_N = 4'd14;

	// baseline filter set, rising / falling / touched, then debounce and filters
	localparam reg_pair_t mpr_cfg_tbl [MPR_CFG_N] = '{
		'{8'h2B, 8'h01},   // mhdr
		'{8'h2C, 8'h01},   // nhdar
		'{8'h2D, 8'h0E},   // nclr
		'{8'h2E, 8'h00},   // fdlr
		'{8'h2F, 8'h01},   // mhdf
		'{8'h30, 8'h05},   // nhdaf
		'{8'h31, 8'h01},   // nclf
		'{8'h32, 8'h00},   // fdlf
		'{8'h33, 8'h00},   // nhdat
		'{8'h34, 8'h00},   // nclt
		'{8'h35, 8'h00},   // fdlt
		'{8'h5B, 8'h00},   // debounce
		'{8'h5C, 8'h10},   // filter cdc
		'{8'h5D, 8'h20}    // filter cdt
	};

	// ==============================
	// ADS1292
	// ==============================
	typedef enum logic [2:0] {
		ADS_IDLE   = 3'b000,
		ADS_WREG   = 3'b010,
		ADS_RDATAC = 3'b100,
		ADS_SDATAC = 3'b101,
		ADS_DUMMY  = 3'b111    // no operation
	} ads_ctrl_e;

	localparam logic [CFG_IDX_W-1:0] ADS_CFG_N = 4'd11;

	// resp regs first, config1/resp writes reset the digital filter anyway
	localparam reg_pair_t ads_cfg_tbl [ADS_CFG_N] = '{
		'{8'h09, 8'h02},   // resp1
		'{8'h0A, 8'h87},   // resp2, bit2 must be set
		'{8'h01, 8'h01},   // config1
		'{8'h02, 8'hE0},   // config2
		'{8'h03, 8'h10},   // loff
		'{8'h04, 8'h00},   // ch1set
		'{8'h05, 8'h00},   // ch2set
		'{8'h06, 8'h2C},   // rld_sens
		'{8'h07, 8'h0E},   // loff_sens
		'{8'h08, 8'h40},   // loff_stat
		'{8'h0B, 8'h00}    // gpio
	};

endpackage

`default_nettype wire

//--- uart_cmd_decoder.sv
/*
 * host command decoder
 * settling counter after reset, run / stop byte decode into a run level
 */
`default_nettype none

module uart_cmd_decoder (
	input  logic                        i_CLK,
	input  logic                        w_rst,
	input  logic [sensor_pkg::RX_W-1:0] i_rx,
	input  logic                        i_rx_valid,
	output logic                        o_run_req
);

	logic [sensor_pkg::SETTLE_W-1:0] r_settle_cnt;
	logic                            w_settled;

	assign w_settled = (r_settle_cnt == sensor_pkg::SETTLE_CYCLES);

	always_ff @(posedge i_CLK or posedge w_rst) begin
		if (w_rst) begin
			r_settle_cnt <= '0;
			o_run_req    <= 1'b0;
		end else begin
			if (!w_settled)
				r_settle_cnt <= r_settle_cnt + 1'b1;   // stops at the limit
			// words seen while settling are dropped
			if (w_settled && i_rx_valid) begin
				case (i_rx[sensor_pkg::RX_W-1 -: 8])
					sensor_pkg::CMD_RUN:  o_run_req <= 1'b1;
					sensor_pkg::CMD_STOP: o_run_req <= 1'b0;
					default: ;   // unknown byte, keep level
				endcase
			end
		end
	end

	// no run request can leak out before the other stages are up
	a_quiet_settle: assert property (@(posedge i_CLK) disable iff (w_rst)
		!w_settled |-> !o_run_req);

endmodule

`default_nettype wire

//--- sensor_sequencer.sv
/*
 * bring-up sequencer
 * waits for both bridges, starts configuration once, gates run
 */
`default_nettype none

module sensor_sequencer (
	input  logic i_CLK,
	input  logic w_rst,
	input  logic i_mpr_init_set,
	input  logic i_ads_init_set,
	input  logic i_run_req,
	input  logic i_mpr_cfg_done,
	input  logic i_ads_cfg_done,
	output logic o_cfg_start,
	output logic o_run
);

	typedef enum logic [1:0] {
		ST_WAIT_INIT,
		ST_CONFIG,
		ST_READY
	} state_e;

	state_e r_state;
	logic   r_cfg_issued;   // start already sent since reset
	logic   w_all_done;

	assign w_all_done = i_mpr_cfg_done & i_ads_cfg_done;

	// ==============================
	// bring-up fsm
	// ==============================
	always_ff @(posedge i_CLK or posedge w_rst) begin
		if (w_rst) begin
			r_state      <= ST_WAIT_INIT;
			r_cfg_issued <= 1'b0;
			o_cfg_start  <= 1'b0;
			o_run        <= 1'b0;
		end else begin
			o_cfg_start  <= 1'b0;                         // single cycle pulse
			r_cfg_issued <= r_cfg_issued | o_cfg_start;
			case (r_state)
				ST_WAIT_INIT: begin
					// both bridges must have finished their own init
					if (i_mpr_init_set && i_ads_init_set) begin
						o_cfg_start <= 1'b1;
						r_state     <= ST_CONFIG;
					end
				end
				ST_CONFIG: begin
					// run request held off until both tables are written
					if (w_all_done) begin
						o_run   <= i_run_req;
						r_state <= ST_READY;
					end
				end
				ST_READY: begin
					o_run <= i_run_req;   // one cycle behind the request
				end
				default: r_state <= ST_WAIT_INIT;
			endcase
		end
	end

	// chips are configured once per reset
	a_one_start: assert property (@(posedge i_CLK) disable iff (w_rst)
		r_cfg_issued |-> !o_cfg_start);

endmodule

`default_nettype wire

//--- mpr121_ctrl.sv
/*
 * MPR121 controller
 * table writes, electrode run / stop, touch status polling
 * sticky bus fail flag
 */
`default_nettype none

module mpr121_ctrl (
	input  logic                              i_CLK,
	input  logic                              w_rst,
	input  logic                              i_cfg_start,
	input  logic                              i_run,
	input  logic [sensor_pkg::REG_DATA_W-1:0] i_rdata,
	input  logic                              i_busy,
	input  logic                              i_fail,
	output logic [sensor_pkg::REG_ADDR_W-1:0] o_addr,
	output logic [sensor_pkg::REG_DATA_W-1:0] o_wdata,
	output logic                              o_wr_en,
	output logic                              o_rd_en,
	output logic                              o_cfg_done,
	output logic [sensor_pkg::TOUCH_W-1:0]    o_touch,
	output logic                              o_error
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_CFG,     // table walk
		ST_POLL,    // next status read or stop
		ST_PULSE,   // enable high on the bus
		ST_BUSY     // wait bridge idle, then check result
	} state_e;

	// where to continue after an access
	typedef enum logic [1:0] {
		RET_CFG,
		RET_RUN,
		RET_STOP,
		RET_POLL
	} ret_e;

	state_e                           r_state;
	ret_e                             r_ret;
	logic [sensor_pkg::CFG_IDX_W-1:0] r_idx;
	logic                             r_sel;     // 0 status0, 1 status1
	logic [7:0]                       r_stat0;   // first half of the pair

	always_ff @(posedge i_CLK or posedge w_rst) begin
		if (w_rst) begin
			r_state    <= ST_IDLE;
			r_ret      <= RET_CFG;
			r_idx      <= '0;
			r_sel      <= 1'b0;
			r_stat0    <= '0;
			o_addr     <= '0;
			o_wdata    <= '0;
			o_wr_en    <= 1'b0;
			o_rd_en    <= 1'b0;
			o_cfg_done <= 1'b0;
			o_touch    <= '0;
			o_error    <= 1'b0;
		end else begin
			case (r_state)
				ST_IDLE: begin
					if (i_cfg_start && !o_cfg_done && !o_error) begin
						r_idx   <= '0;
						r_state <= ST_CFG;
					end else if (i_run && o_cfg_done && !o_error) begin
						o_addr  <= sensor_pkg::MPR_ELE_CFG_REG;   // electrodes on
						o_wdata <= sensor_pkg::MPR_ELE_RUN;
						o_wr_en <= 1'b1;
						r_ret   <= RET_RUN;
						r_state <= ST_PULSE;
					end
				end
				ST_CFG: begin
					if (r_idx == sensor_pkg::MPR_CFG_N) begin
						o_cfg_done <= 1'b1;   // held until reset
						r_state    <= ST_IDLE;
					end else begin
						o_addr  <= sensor_pkg::mpr_cfg_tbl[r_idx].addr;
						o_wdata <= sensor_pkg::mpr_cfg_tbl[r_idx].data;
						o_wr_en <= 1'b1;
						r_idx   <= r_idx + 1'b1;
						r_ret   <= RET_CFG;
						r_state <= ST_PULSE;
					end
				end
				ST_POLL: begin
					if (!i_run) begin
						o_addr  <= sensor_pkg::MPR_ELE_CFG_REG;   // electrodes off
						o_wdata <= sensor_pkg::MPR_ELE_STOP;
						o_wr_en <= 1'b1;
						r_ret   <= RET_STOP;
					end else begin
						o_addr  <= r_sel ? sensor_pkg::MPR_TOUCH1_REG : sensor_pkg::MPR_TOUCH0_REG;
						o_rd_en <= 1'b1;
						r_ret   <= RET_POLL;
					end
					r_state <= ST_PULSE;
				end
				ST_PULSE: begin
					o_wr_en <= 1'b0;
					o_rd_en <= 1'b0;
					r_state <= ST_BUSY;
				end
				ST_BUSY: begin
					if (!i_busy) begin
						if (i_fail) begin
							o_error <= 1'b1;   // sticky
							r_state <= ST_IDLE;
						end else begin
							case (r_ret)
								RET_CFG:  r_state <= ST_CFG;
								RET_RUN: begin
									r_sel   <= 1'b0;   // always start with status0
									r_state <= ST_POLL;
								end
								RET_STOP: r_state <= ST_IDLE;
								RET_POLL: begin
									r_sel <= ~r_sel;
									if (r_sel)   // pair complete, ele8..11 in low nibble
										o_touch <= {4'b0, i_rdata[3:0], r_stat0};
									else
										r_stat0 <= i_rdata;
									r_state <= ST_POLL;
								end
							endcase
						end
					end
				end
				default: r_state <= ST_IDLE;
			endcase
		end
	end

	// bridge takes one access at a time
	a_one_enable: assert property (@(posedge i_CLK) disable iff (w_rst)
		!(o_wr_en && o_rd_en));

endmodule

`default_nettype wire

//--- ads1292_ctrl.sv
/*
 * ADS1292 controller
 * WREG table walk, RDATAC / SDATAC on run edges, sample capture with ack
 */
`default_nettype none

module ads1292_ctrl (
	input  logic                              i_CLK,
	input  logic                              w_rst,
	input  logic                              i_cfg_start,
	input  logic                              i_run,
	input  logic                              i_busy,
	input  logic [sensor_pkg::SAMPLE_W-1:0]   i_sample,
	input  logic                              i_sample_valid,
	output sensor_pkg::ads_ctrl_e             o_ctrl,
	output logic [sensor_pkg::REG_ADDR_W-1:0] o_addr,
	output logic [sensor_pkg::REG_DATA_W-1:0] o_wdata,
	output logic                              o_cfg_done,
	output logic                              o_sample_ack,
	output logic [sensor_pkg::SAMPLE_W-1:0]   o_sample,
	output logic                              o_sample_stb
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_CFG,
		ST_PULSE,    // WREG on the bus
		ST_BUSY,
		ST_STREAM    // RDATAC mode
	} state_e;

	state_e                           r_state;
	logic [sensor_pkg::CFG_IDX_W-1:0] r_idx;
	logic                             r_ack;
	logic                             w_take;

	// no back-to-back take, ack cycle is skipped
	assign w_take       = (r_state == ST_STREAM) && i_run && i_sample_valid && !r_ack;
	assign o_sample_ack = r_ack;
	assign o_sample_stb = r_ack;   // packer sees the same cycle

	always_ff @(posedge i_CLK or posedge w_rst) begin
		if (w_rst) begin
			r_state    <= ST_IDLE;
			r_idx      <= '0;
			r_ack      <= 1'b0;
			o_ctrl     <= sensor_pkg::ADS_IDLE;
			o_addr     <= '0;
			o_wdata    <= '0;
			o_cfg_done <= 1'b0;
		end else begin
			o_ctrl <= sensor_pkg::ADS_DUMMY;   // codes last one cycle
			r_ack  <= w_take;
			case (r_state)
				ST_IDLE: begin
					if (i_cfg_start && !o_cfg_done) begin
						r_idx   <= '0;
						r_state <= ST_CFG;
					end else if (i_run && o_cfg_done) begin
						o_ctrl  <= sensor_pkg::ADS_RDATAC;
						r_state <= ST_STREAM;
					end
				end
				ST_CFG: begin
					if (r_idx == sensor_pkg::ADS_CFG_N) begin
						o_cfg_done <= 1'b1;
						r_state    <= ST_IDLE;
					end else begin
						o_ctrl  <= sensor_pkg::ADS_WREG;
						o_addr  <= sensor_pkg::ads_cfg_tbl[r_idx].addr;
						o_wdata <= sensor_pkg::ads_cfg_tbl[r_idx].data;
						r_idx   <= r_idx + 1'b1;
						r_state <= ST_PULSE;
					end
				end
				ST_PULSE: r_state <= ST_BUSY;   // busy checked from the next cycle
				ST_BUSY: begin
					if (!i_busy)
						r_state <= ST_CFG;
				end
				ST_STREAM: begin
					if (!i_run) begin
						o_ctrl  <= sensor_pkg::ADS_SDATAC;   // leave continuous mode
						r_state <= ST_IDLE;
					end
				end
				default: r_state <= ST_IDLE;
			endcase
		end
	end

	// sample payload
	always_ff @(posedge i_CLK) begin
		if (w_take)
			o_sample <= i_sample;
	end

endmodule

`default_nettype wire

//--- frame_packer.sv
/*
 * frame packer
 * one-entry buffer, head / sample / touch / tail, valid held until ready
 */
`default_nettype none

module frame_packer (
	input  logic                             i_CLK,
	input  logic                             w_rst,
	input  logic [sensor_pkg::SAMPLE_W-1:0]  i_sample,
	input  logic                             i_sample_stb,
	input  logic [sensor_pkg::TOUCH_W-1:0]   i_touch,
	input  logic                             i_tx_ready,
	output logic [sensor_pkg::FRAME_W-1:0]   o_tx,
	output logic                             o_tx_valid
);

	logic w_load;

	// buffer full drops the sample
	assign w_load = i_sample_stb && !o_tx_valid;

	always_ff @(posedge i_CLK or posedge w_rst) begin
		if (w_rst)
			o_tx_valid <= 1'b0;
		else if (w_load)
			o_tx_valid <= 1'b1;
		else if (i_tx_ready)
			o_tx_valid <= 1'b0;   // handshake done
	end

	// msb first on the wire
	always_ff @(posedge i_CLK) begin
		if (w_load)
			o_tx <= {sensor_pkg::FRAME_HEAD, i_sample, i_touch, sensor_pkg::FRAME_TAIL};
	end

	// frame must not move under back-pressure
	a_tx_hold: assert property (@(posedge i_CLK) disable iff (w_rst)
		(o_tx_valid && !i_tx_ready) |=> (o_tx_valid && $stable(o_tx)));

endmodule

`default_nettype wire

//--- sensor_core.sv
/*
 * sensor hub top
 * reset synchronizer, decoder, sequencer, chip controllers, packer
 */
`default_nettype none

module sensor_core (
	input  logic                              i_CLK,
	input  logic                              i_RSTN,
	input  logic [sensor_pkg::RX_W-1:0]       i_uart_rx,
	input  logic                              i_uart_rx_valid,
	input  logic                              i_uart_tx_ready,
	output logic [sensor_pkg::FRAME_W-1:0]    o_uart_tx,
	output logic                              o_uart_tx_valid,
	input  logic [sensor_pkg::REG_DATA_W-1:0] i_mpr_rdata,
	input  logic                              i_mpr_init_set,
	input  logic                              i_mpr_busy,
	input  logic                              i_mpr_fail,
	output logic [sensor_pkg::REG_ADDR_W-1:0] o_mpr_addr,
	output logic [sensor_pkg::REG_DATA_W-1:0] o_mpr_wdata,
	output logic                              o_mpr_wr_en,
	output logic                              o_mpr_rd_en,
	output logic                              o_mpr_error,
	input  logic [sensor_pkg::SAMPLE_W-1:0]   i_ads_sample,
	input  logic                              i_ads_sample_valid,
	input  logic                              i_ads_init_set,
	input  logic                              i_ads_busy,
	output sensor_pkg::ads_ctrl_e             o_ads_ctrl,
	output logic [sensor_pkg::REG_ADDR_W-1:0] o_ads_addr,
	output logic [sensor_pkg::REG_DATA_W-1:0] o_ads_wdata,
	output logic                              o_ads_sample_ack
);

	logic [1:0]                         r_rst_sync;
	logic                               w_rst;
	logic                               w_run_req, w_cfg_start, w_run;
	logic                               w_mpr_cfg_done, w_ads_cfg_done;
	logic [sensor_pkg::TOUCH_W-1:0]     w_touch;
	logic [sensor_pkg::SAMPLE_W-1:0]    w_sample;
	logic                               w_sample_stb;

	// async assert, release after two clean edges
	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN)
			r_rst_sync <= 2'b11;
		else
			r_rst_sync <= {r_rst_sync[0], 1'b0};
	end
	assign w_rst = r_rst_sync[1];

	uart_cmd_decoder u_dec (.i_CLK, .w_rst, .i_rx(i_uart_rx), .i_rx_valid(i_uart_rx_valid),
		.o_run_req(w_run_req));

	sensor_sequencer u_seq (.i_CLK, .w_rst, .i_mpr_init_set, .i_ads_init_set,
		.i_run_req(w_run_req), .i_mpr_cfg_done(w_mpr_cfg_done),
		.i_ads_cfg_done(w_ads_cfg_done), .o_cfg_start(w_cfg_start), .o_run(w_run));

	mpr121_ctrl u_mpr (.i_CLK, .w_rst, .i_cfg_start(w_cfg_start), .i_run(w_run),
		.i_rdata(i_mpr_rdata), .i_busy(i_mpr_busy), .i_fail(i_mpr_fail),
		.o_addr(o_mpr_addr), .o_wdata(o_mpr_wdata), .o_wr_en(o_mpr_wr_en),
		.o_rd_en(o_mpr_rd_en), .o_cfg_done(w_mpr_cfg_done), .o_touch(w_touch),
		.o_error(o_mpr_error));

	ads1292_ctrl u_ads (.i_CLK, .w_rst, .i_cfg_start(w_cfg_start), .i_run(w_run),
		.i_busy(i_ads_busy), .i_sample(i_ads_sample), .i_sample_valid(i_ads_sample_valid),
		.o_ctrl(o_ads_ctrl), .o_addr(o_ads_addr), .o_wdata(o_ads_wdata),
		.o_cfg_done(w_ads_cfg_done), .o_sample_ack(o_ads_sample_ack),
		.o_sample(w_sample), .o_sample_stb(w_sample_stb));

	frame_packer u_pack (.i_CLK, .w_rst, .i_sample(w_sample), .i_sample_stb(w_sample_stb),
		.i_touch(w_touch), .i_tx_ready(i_uart_tx_ready), .o_tx(o_uart_tx),
		.o_tx_valid(o_uart_tx_valid));

endmodule

`default_nettype wire

//--- tb_sensor_tests.svh
/*
 * directed tests for the sensor hub testbench
 * host command, sample and frame drivers, one task per behavior
 */
`ifndef TB_SENSOR_TESTS_SVH
`define TB_SENSOR_TESTS_SVH

// one RX word, command in the upper byte
task automatic send_cmd(input logic [7:0] cmd);
	i_uart_rx       = {cmd, 8'h00};
	i_uart_rx_valid = 1'b1;
	@(negedge i_CLK);
	i_uart_rx_valid = 1'b0;
endtask

// hold valid until the controller acks
task automatic offer_sample(input logic [23:0] value);
	i_ads_sample       = value;
	i_ads_sample_valid = 1'b1;
	@(negedge i_CLK);
	while (!o_ads_sample_ack) @(negedge i_CLK);
	i_ads_sample_valid = 1'b0;
endtask

task automatic take_frame(output logic [55:0] frame);
	while (!o_uart_tx_valid) @(negedge i_CLK);
	frame           = o_uart_tx;
	i_uart_tx_ready = 1'b1;   // handshake on the next rising edge
	@(negedge i_CLK);
	i_uart_tx_ready = 1'b0;
endtask

// ==============================
// tests
// ==============================
task automatic reset_and_settle();
	apply_reset();
	// sync still holds reset here
	check("tx_valid after reset", 64'(o_uart_tx_valid), 64'd0);
	check("mpr wr_en after reset", 64'(o_mpr_wr_en), 64'd0);
	check("mpr rd_en after reset", 64'(o_mpr_rd_en), 64'd0);
	check("sample ack after reset", 64'(o_ads_sample_ack), 64'd0);
	check("mpr error after reset", 64'(o_mpr_error), 64'd0);
	check("ads ctrl after reset", 64'(o_ads_ctrl), 64'(sensor_pkg::ADS_IDLE));
	repeat (4) @(negedge i_CLK);
	send_cmd(sensor_pkg::CMD_RUN);   // inside the settling window
	repeat (int'(sensor_pkg::SETTLE_CYCLES) + 4) @(negedge i_CLK);
	i_mpr_init_set = 1'b1;
	i_ads_init_set = 1'b1;
	while (mpr_log.size() < mpr_n || ads_log.size() < ads_n) @(negedge i_CLK);
	repeat (30) @(negedge i_CLK);
	// a dropped run leaves both chips configured but stopped
	check("mpr writes without run", 64'(mpr_log.size()), 64'(mpr_n));
	check("ads events without run", 64'(ads_log.size()), 64'(ads_n));
endtask

task automatic cfg_tables();
	mpr_log.delete();
	ads_log.delete();
	apply_reset();   // init_set still high, bring-up starts at once
	repeat (int'(sensor_pkg::SETTLE_CYCLES) + 4) @(negedge i_CLK);
	check("config busy at run cmd", 64'(mpr_log.size() < mpr_n), 64'd1);
	send_cmd(sensor_pkg::CMD_RUN);
	while (mpr_log.size() < mpr_n || ads_log.size() < ads_n) @(negedge i_CLK);
	for (int i = 0; i < mpr_n; i++)
		check("mpr table write", 64'(mpr_log[i]), 64'(sensor_pkg::mpr_cfg_tbl[i]));
	for (int i = 0; i < ads_n; i++)
		check("ads table wreg", 64'(ads_log[i]),
			64'({sensor_pkg::ADS_WREG, sensor_pkg::ads_cfg_tbl[i]}));
endtask

task automatic run_and_frames();
	logic [23:0] s;
	logic [55:0] f;
	int          r0;
	while (mpr_log.size() <= mpr_n || ads_log.size() <= ads_n) @(negedge i_CLK);
	// early run only lands after the tables
	check("electrode run write", 64'(mpr_log[mpr_n]),
		64'({sensor_pkg::MPR_ELE_CFG_REG, sensor_pkg::MPR_ELE_RUN}));
	check("rdatac after tables", 64'(ads_log[ads_n]), 64'({sensor_pkg::ADS_RDATAC, 16'h0000}));
	mpr_stat0 = 8'(rand_bits(8));
	mpr_stat1 = 8'(rand_bits(8));
	exp_touch = {4'h0, mpr_stat1[3:0], mpr_stat0};
	r0 = mpr_reads;
	while (mpr_reads < r0 + 4) @(negedge i_CLK);   // at least one full pair
	for (int k = 0; k < 3; k++) begin
		s = 24'(rand_bits(24));
		offer_sample(s);
		take_frame(f);
		check("frame", 64'(f), 64'({sensor_pkg::FRAME_HEAD, s, exp_touch, sensor_pkg::FRAME_TAIL}));
	end
endtask

task automatic backpressure();
	logic [23:0] s;
	logic [55:0] held;
	logic [55:0] f;
	s = 24'(rand_bits(24));
	offer_sample(s);
	@(negedge i_CLK);
	check("tx_valid one cycle after sample", 64'(o_uart_tx_valid), 64'd1);
	held = o_uart_tx;
	check("first frame", 64'(held),
		64'({sensor_pkg::FRAME_HEAD, s, exp_touch, sensor_pkg::FRAME_TAIL}));
	repeat (2) begin
		offer_sample(24'(rand_bits(24)));   // acked, then dropped
		repeat (2) @(negedge i_CLK);
		check("tx_valid held", 64'(o_uart_tx_valid), 64'd1);
		check("frame held", 64'(o_uart_tx), 64'(held));
	end
	i_uart_tx_ready = 1'b1;
	@(negedge i_CLK);
	i_uart_tx_ready = 1'b0;
	check("no frame from dropped samples", 64'(o_uart_tx_valid), 64'd0);
	s = 24'(rand_bits(24));
	offer_sample(s);
	take_frame(f);
	check("frame after handshake", 64'(f),
		64'({sensor_pkg::FRAME_HEAD, s, exp_touch, sensor_pkg::FRAME_TAIL}));
endtask

task automatic stop_run();
	int m0;
	int a0;
	m0 = mpr_log.size();
	a0 = ads_log.size();
	send_cmd(sensor_pkg::CMD_STOP);
	while (mpr_log.size() == m0 || ads_log.size() == a0) @(negedge i_CLK);
	check("sdatac on stop", 64'(ads_log[a0]), 64'({sensor_pkg::ADS_SDATAC, 16'h0000}));
	check("electrode stop write", 64'(mpr_log[m0]),
		64'({sensor_pkg::MPR_ELE_CFG_REG, sensor_pkg::MPR_ELE_STOP}));
	i_ads_sample       = 24'(rand_bits(24));
	i_ads_sample_valid = 1'b1;   // nobody takes it now
	repeat (10) begin
		@(negedge i_CLK);
		check("no ack after stop", 64'(o_ads_sample_ack), 64'd0);
		check("no frame after stop", 64'(o_uart_tx_valid), 64'd0);
	end
	i_ads_sample_valid = 1'b0;
endtask

task automatic mpr_fail();
	int acc;
	mpr_fail_next = 1'b1;   // electrode run write fails
	send_cmd(sensor_pkg::CMD_RUN);
	while (!o_mpr_error) @(negedge i_CLK);
	acc = mpr_accesses;
	repeat (20) begin
		@(negedge i_CLK);
		check("mpr error sticky", 64'(o_mpr_error), 64'd1);
	end
	check("mpr quiet after fail", 64'(mpr_accesses), 64'(acc));
endtask

`endif

//--- tb_sensor_core.sv
/*
 * testbench top for the sensor hub
 * clock, reset, LFSR, compare task, watchdog
 * MPR121 and ADS1292 bridge models, directed tests from the header
 */
`default_nettype none

module tb_sensor_core;

	timeunit 1ns;
	timeprecision 1ps;

	logic                  i_CLK = 1'b0;   // low before the first edge
	logic                  i_RSTN;
	logic [15:0]           i_uart_rx;
	logic                  i_uart_rx_valid;
	logic                  i_uart_tx_ready;
	logic [55:0]           o_uart_tx;
	logic                  o_uart_tx_valid;
	logic [7:0]            i_mpr_rdata;
	logic                  i_mpr_init_set, i_mpr_busy, i_mpr_fail;
	logic [7:0]            o_mpr_addr, o_mpr_wdata;
	logic                  o_mpr_wr_en, o_mpr_rd_en, o_mpr_error;
	logic [23:0]           i_ads_sample;
	logic                  i_ads_sample_valid, i_ads_init_set, i_ads_busy;
	sensor_pkg::ads_ctrl_e o_ads_ctrl;
	logic [7:0]            o_ads_addr, o_ads_wdata;
	logic                  o_ads_sample_ack;

	logic [31:0] lfsr_state;
	int          n_tests = 6;
	int          mpr_n = int'(sensor_pkg::MPR_CFG_N);
	int          ads_n = int'(sensor_pkg::ADS_CFG_N);

	// bridge model state
	logic [15:0] mpr_log[$];     // logged writes as {addr, data}
	logic [18:0] ads_log[$];     // {ctrl, addr, data}
	logic [7:0]  mpr_stat0, mpr_stat1;
	logic        mpr_fail_next;  // next access answers with fail
	int          mpr_reads = 0;
	int          mpr_accesses = 0;
	logic [15:0] exp_touch;

	sensor_core dut (
		.i_CLK(i_CLK), .i_RSTN(i_RSTN),
		.i_uart_rx(i_uart_rx), .i_uart_rx_valid(i_uart_rx_valid),
		.i_uart_tx_ready(i_uart_tx_ready), .o_uart_tx(o_uart_tx),
		.o_uart_tx_valid(o_uart_tx_valid),
		.i_mpr_rdata(i_mpr_rdata), .i_mpr_init_set(i_mpr_init_set),
		.i_mpr_busy(i_mpr_busy), .i_mpr_fail(i_mpr_fail),
		.o_mpr_addr(o_mpr_addr), .o_mpr_wdata(o_mpr_wdata),
		.o_mpr_wr_en(o_mpr_wr_en), .o_mpr_rd_en(o_mpr_rd_en), .o_mpr_error(o_mpr_error),
		.i_ads_sample(i_ads_sample), .i_ads_sample_valid(i_ads_sample_valid),
		.i_ads_init_set(i_ads_init_set), .i_ads_busy(i_ads_busy),
		.o_ads_ctrl(o_ads_ctrl), .o_ads_addr(o_ads_addr), .o_ads_wdata(o_ads_wdata),
		.o_ads_sample_ack(o_ads_sample_ack)
	);

	// ==============================
	// clock, lfsr, compare, reset
	// ==============================
	initial begin
		forever #10 i_CLK = ~i_CLK;   // 20 ns
	end

	// fibonacci with taps 32 22 2 1 stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			v          = {v[30:0], fb};
		end
		return v;
	endfunction

	task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	// two cycles low and released on a falling edge
	task automatic apply_reset();
		i_RSTN = 1'b0;
		repeat (2) @(negedge i_CLK);
		i_RSTN = 1'b1;
	endtask

	`include "tb_sensor_tests.svh"

	// ==============================
	// bridge models
	// ==============================
	initial begin : mpr_model
		int n;
		i_mpr_busy  = 1'b0;
		i_mpr_fail  = 1'b0;
		i_mpr_rdata = '0;
		forever begin
			@(negedge i_CLK);
			if (o_mpr_wr_en || o_mpr_rd_en) begin
				mpr_accesses++;
				if (o_mpr_wr_en)
					mpr_log.push_back({o_mpr_addr, o_mpr_wdata});
				else
					mpr_reads++;
				i_mpr_rdata   = (o_mpr_addr == sensor_pkg::MPR_TOUCH1_REG) ?
					mpr_stat1 : mpr_stat0;
				i_mpr_fail    = mpr_fail_next;
				mpr_fail_next = 1'b0;
				i_mpr_busy    = 1'b1;
				n = 1 + rand_bits(2);   // 1..4 cycles busy
				repeat (n) @(negedge i_CLK);
				i_mpr_busy = 1'b0;
			end
		end
	end

	initial begin : ads_model
		int n;
		i_ads_busy = 1'b0;
		forever begin
			@(negedge i_CLK);
			if (o_ads_ctrl == sensor_pkg::ADS_WREG) begin
				ads_log.push_back({o_ads_ctrl, o_ads_addr, o_ads_wdata});
				i_ads_busy = 1'b1;
				n = 1 + rand_bits(2);
				repeat (n) @(negedge i_CLK);
				i_ads_busy = 1'b0;
			end else if (o_ads_ctrl == sensor_pkg::ADS_RDATAC ||
					o_ads_ctrl == sensor_pkg::ADS_SDATAC) begin
				ads_log.push_back({o_ads_ctrl, 16'h0000});   // mode codes carry no payload
			end
		end
	end

	// ==============================
	// watchdog and test sequence
	// ==============================
	initial begin
		repeat (200 * n_tests) @(posedge i_CLK);
		$display("Testbench failed");
		$fatal(1, "timeout: tests did not finish within %0d cycles", 200 * n_tests);
	end

	initial begin
		lfsr_state         = 32'haaf684e9;
		i_RSTN             = 1'b0;
		i_uart_rx          = '0;
		i_uart_rx_valid    = 1'b0;
		i_uart_tx_ready    = 1'b0;
		i_mpr_init_set     = 1'b0;
		i_ads_init_set     = 1'b0;
		i_ads_sample       = '0;
		i_ads_sample_valid = 1'b0;
		mpr_stat0          = '0;
		mpr_stat1          = '0;
		mpr_fail_next      = 1'b0;
		exp_touch          = '0;

		reset_and_settle();
		cfg_tables();
		run_and_frames();
		backpressure();
		stop_run();
		mpr_fail();

		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sensor_core.f
+incdir+.
sensor_pkg.sv
uart_cmd_decoder.sv
sensor_sequencer.sv
mpr121_ctrl.sv
ads1292_ctrl.sv
frame_packer.sv
sensor_core.sv
tb_sensor_core.sv

//--- Makefile
# Verilator flow for the sensor hub: lint, sim, clean
VERILATOR ?= verilator
FILELIST  ?= sensor_core.f
TB_TOP    ?= tb_sensor_core
RTL_TOP   ?= sensor_core
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
FAIL_MSG  ?= Testbench failed
PASS_MSG  ?= Testbench passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o $(TB_TOP)

sim: build
	./$(BUILD_DIR)/$(TB_TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "sim: FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "sim: no result in log"; exit 1; fi
	@echo "sim: PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
